// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - flush_sweep_counter.sv
      - dcache_tag_array.sv
      - dcache_data_array.sv
      - dcache_ctrl_fsm.sv
      - dcache.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - dcache_props.sv
      - tb_dcache.sv

// File: dcache.sv
// processor holds ren or wen until hit and raises halt only with no access pending
`timescale 1ns/1ps
`default_nettype none

module dcache (
   input  logic                 CLK,
   input  logic                 nRST,
   input  dcache_pkg::cpu_req_t req,
   output dcache_pkg::cpu_rsp_t rsp,
   output dcache_pkg::mem_req_t mem_req,
   input  logic                 dwait,
   input  dcache_pkg::word_t    dload
);
   import dcache_pkg::*;

   dcache_addr_t cpu_addr;     // request address split
   dcache_addr_t bus_addr;     // address on the memory bus, drives the write-back port
   logic         access, store_hit;
   logic         hit, victim_dirty, flush_valid, flush_last;
   logic         fill_we, fill_tag_we, wb_clean, flush_inval, flush_step, flushed;
   way_t         hit_way, victim_way, flush_way;
   tag_t         victim_tag;
   idx_t         flush_idx;
   word_t        rdata, wb_word, fill_word;
   blkoff_t      fill_off;

   assign cpu_addr  = dcache_addr_t'(req.addr);
   assign bus_addr  = dcache_addr_t'(mem_req.addr);
   assign access    = req.ren || req.wen;
   assign store_hit = req.wen && hit;

   assign rsp.hit     = hit;
   assign rsp.rdata   = rdata;
   assign rsp.flushed = flushed;

   dcache_ctrl_fsm ctrl_i (
      .CLK, .nRST, .req, .hit, .victim_dirty, .victim_tag, .wb_word,
      .dwait, .dload, .flush_last, .flush_idx, .flush_way, .flush_valid,
      .mem_req, .fill_we, .fill_tag_we, .wb_clean, .flush_inval,
      .flush_step, .flushed, .fill_word, .fill_off
   );

   flush_sweep_counter sweep_i (
      .CLK, .nRST,
      .step (flush_step),
      .idx  (flush_idx),
      .way  (flush_way),
      .last (flush_last)
   );

   dcache_tag_array tags_i (
      .CLK, .nRST,
      .idx          (cpu_addr.idx),
      .tag          (cpu_addr.tag),
      .access, .store_hit, .fill_tag_we, .wb_clean,
      .flush_idx, .flush_way, .flush_inval,
      .hit, .hit_way, .victim_way, .victim_tag, .victim_dirty, .flush_valid
   );

   dcache_data_array data_i (
      .CLK, .nRST,
      .idx        (cpu_addr.idx),
      .blkoff     (cpu_addr.blkoff),
      .rd_way     (hit_way),
      .store_we   (store_hit),
      .wdata      (req.wdata),
      .fill_we,
      .fill_way   (victim_way),     // refill goes where the victim was
      .fill_off, .fill_word,
      .rd_idx     (bus_addr.idx),
      .rd_off     (bus_addr.blkoff),
      .rd_sel_way (victim_way),     // swept way while flushing
      .rdata, .wb_word
   );

endmodule

`default_nettype wire

// File: dcache_config.svh
// sizes assume a 32-bit byte address; the LRU scheme only supports two ways
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// datapath widths
`define DCACHE_WORD_W       32 // one data word
`define DCACHE_ADDR_W       32 // byte address from the processor

// geometry
`define DCACHE_SETS         8
`define DCACHE_IDX_W        3  // log2 of the set count
`define DCACHE_WAYS         2  // two-way, one LRU bit per set
`define DCACHE_BLK_WORDS    2  // words per block
`define DCACHE_BLKOFF_W     1  // word select inside a block

// address split: tag | idx | blkoff | byte offset
`define DCACHE_BYTE_OFF_W   2
`define DCACHE_TAG_W        26 // what is left above idx and offsets

// flush visits every way of every set once
`define DCACHE_FLUSH_STEPS  (`DCACHE_SETS * `DCACHE_WAYS)

`endif

// File: dcache_ctrl_fsm.sv
// every non-idle state waits for dwait low; memory must keep dwait low when no request is up
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl_fsm (
   input  logic                 CLK,
   input  logic                 nRST,
   input  dcache_pkg::cpu_req_t req,
   input  logic                 hit,
   input  logic                 victim_dirty,
   input  dcache_pkg::tag_t     victim_tag,
   input  dcache_pkg::word_t    wb_word,
   input  logic                 dwait,
   input  dcache_pkg::word_t    dload,
   input  logic                 flush_last,
   input  dcache_pkg::idx_t     flush_idx,
   input  dcache_pkg::way_t     flush_way,
   input  logic                 flush_valid,
   output dcache_pkg::mem_req_t mem_req,
   output logic                 fill_we,
   output logic                 fill_tag_we,
   output logic                 wb_clean,
   output logic                 flush_inval,
   output logic                 flush_step,
   output logic                 flushed,
   output dcache_pkg::word_t    fill_word,
   output dcache_pkg::blkoff_t  fill_off
);
   import dcache_pkg::*;

   ctrl_state_t  state, next_state;
   dcache_addr_t req_addr;
   dcache_addr_t mem_addr;
   blkoff_t      word_off;
   logic         miss, go, sweeping, sweep_end;

   assign req_addr  = dcache_addr_t'(req.addr);
   assign miss      = (req.ren || req.wen) && !hit;
   assign go        = !dwait;                           // memory accepted this word
   assign sweeping  = (state == FLUSH_W1) || (state == FLUSH_W2);
   assign sweep_end = flush_last && (flush_way == way_t'(`DCACHE_WAYS - 1)); // top way, last set
   assign word_off  = blkoff_t'((state == WB2) || (state == FILL2) || (state == FLUSH_W2));

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (miss && victim_dirty) begin
               next_state = WB1;        // old block goes out first
            end else if (miss) begin
               next_state = FILL1;
            end else if (req.halt) begin
               next_state = FLUSH_W1;
            end
         end
         WB1:      if (go) next_state = WB2;
         WB2:      if (go) next_state = FILL1;
         FILL1:    if (go) next_state = FILL2;
         FILL2:    if (go) next_state = IDLE;   // access then hits in idle
         FLUSH_W1: if (go) next_state = FLUSH_W2;
         FLUSH_W2: if (go) next_state = sweep_end ? DONE : FLUSH_W1;
         DONE:     next_state = DONE;           // parked until reset
         default:  next_state = IDLE;
      endcase
   end

   // block address of the word being moved
   always_comb begin
      mem_addr = '0;
      case (state)
         WB1, WB2:           mem_addr = '{victim_tag, req_addr.idx, word_off, '0};
         FILL1, FILL2:       mem_addr = '{req_addr.tag, req_addr.idx, word_off, '0};
         FLUSH_W1, FLUSH_W2: mem_addr = '{victim_tag, flush_idx, word_off, '0};
         default:            mem_addr = '0;
      endcase
   end

   assign mem_req.ren   = (state == FILL1) || (state == FILL2);
   assign mem_req.wen   = (state == WB1) || (state == WB2) || (sweeping && flush_valid);
   assign mem_req.addr  = mem_addr;
   assign mem_req.wdata = wb_word;                 // don't care on reads

   // array strobes, one per accepted word
   assign fill_we     = ((state == FILL1) || (state == FILL2)) && go;
   assign fill_tag_we = (state == FILL2) && go;      // block complete
   assign wb_clean    = (state == WB2) && go;
   assign flush_inval = (state == FLUSH_W2) && go && flush_valid;
   assign flush_step  = (state == FLUSH_W2) && go;  // invalid blocks pass without a write
   assign flushed     = (state == DONE);
   assign fill_word   = dload;
   assign fill_off    = word_off;

endmodule

`default_nettype wire

// File: dcache_data_array.sv
// store and fill never coincide, store wins if they ever do; reads are combinational
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_data_array (
   input  logic                CLK,
   input  logic                nRST,
   input  dcache_pkg::idx_t    idx,
   input  dcache_pkg::blkoff_t blkoff,
   input  dcache_pkg::way_t    rd_way,
   input  logic                store_we,
   input  dcache_pkg::word_t   wdata,
   input  logic                fill_we,
   input  dcache_pkg::way_t    fill_way,
   input  dcache_pkg::blkoff_t fill_off,
   input  dcache_pkg::word_t   fill_word,
   input  dcache_pkg::idx_t    rd_idx,
   input  dcache_pkg::blkoff_t rd_off,
   input  dcache_pkg::way_t    rd_sel_way,
   output dcache_pkg::word_t   rdata,
   output dcache_pkg::word_t   wb_word
);
   import dcache_pkg::*;

   // way, set, word in block
   word_t data [`DCACHE_WAYS][`DCACHE_SETS][`DCACHE_BLK_WORDS];

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         data <= '{default: '0}; // clean contents out of reset
      end else if (store_we) begin
         // store hit lands at the edge that ends the hit cycle
         data[rd_way][idx][blkoff] <= wdata;
      end else if (fill_we) begin
         data[fill_way][idx][fill_off] <= fill_word; // refill into the victim
      end
   end

   // processor port, word of the way that hit
   assign rdata = data[rd_way][idx][blkoff];

   // second port feeds write-back and flush data to memory,
   // addressed by the word currently on the memory bus
   assign wb_word = data[rd_sel_way][rd_idx][rd_off];

endmodule

`default_nettype wire

// File: dcache_pkg.sv
// types shared by the cache modules; widths come from dcache_config.svh
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

   typedef logic [`DCACHE_WORD_W-1:0]          word_t;
   typedef logic [`DCACHE_ADDR_W-1:0]          addr_t;
   typedef logic [`DCACHE_TAG_W-1:0]           tag_t;
   typedef logic [`DCACHE_IDX_W-1:0]           idx_t;
   typedef logic [`DCACHE_BLKOFF_W-1:0]        blkoff_t;
   typedef logic [$clog2(`DCACHE_WAYS)-1:0]    way_t;

   // processor address as the cache sees it
   typedef struct packed {
      tag_t                           tag;
      idx_t                           idx;
      blkoff_t                        blkoff;
      logic [`DCACHE_BYTE_OFF_W-1:0]  byteoff; // ignored, word accesses only
   } dcache_addr_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      logic  halt;   // level, held once raised
      addr_t addr;
      word_t wdata;
   } cpu_req_t;

   typedef struct packed {
      logic  hit;    // completes the held access
      word_t rdata;
      logic  flushed;
   } cpu_rsp_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      addr_t addr;
      word_t wdata;
   } mem_req_t;

   typedef enum logic [2:0] {
      IDLE, WB1, WB2, FILL1, FILL2, FLUSH_W1, FLUSH_W2, DONE
   } ctrl_state_t;

   localparam int FLUSH_STEPS = `DCACHE_FLUSH_STEPS;

endpackage

`default_nettype wire

// File: dcache_props.sv
// memory side must hold dwait low while no request is up; checks sampled on the rising edge
`timescale 1ns/1ps
`default_nettype none

module dcache_props (
   input logic                 CLK,
   input logic                 nRST,
   input dcache_pkg::cpu_req_t req,
   input dcache_pkg::cpu_rsp_t rsp,
   input dcache_pkg::mem_req_t mem_req,
   input logic                 dwait
);
   int fail_count = 0;  // read by the testbench every cycle

   // a stalled request may not move until memory takes it
   property req_held_in_wait;
      @(posedge CLK) disable iff (!nRST)
         dwait && (mem_req.ren || mem_req.wen) |=> $stable(mem_req);
   endproperty

   assert property (req_held_in_wait) else begin
      fail_count++;
      $error("memory request changed while dwait was high");
   end

   assert property (@(posedge CLK) disable iff (!nRST) !(mem_req.ren && mem_req.wen)) else begin
      fail_count++;
      $error("memory read and write requested in the same cycle");
   end

   // DONE is reached only through the sweep that halt starts
   assert property (@(posedge CLK) disable iff (!nRST) rsp.flushed |-> req.halt) else begin
      fail_count++;
      $error("flushed raised without a halt request");
   end

endmodule

bind dcache dcache_props props_i (.*);

`default_nettype wire

// File: dcache_tag_array.sv
// two ways only; with no access pending the victim port follows the flush position
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_tag_array (
   input  logic             CLK,
   input  logic             nRST,
   input  dcache_pkg::idx_t idx,
   input  dcache_pkg::tag_t tag,
   input  logic             access,
   input  logic             store_hit,
   input  logic             fill_tag_we,
   input  logic             wb_clean,
   input  dcache_pkg::idx_t flush_idx,
   input  dcache_pkg::way_t flush_way,
   input  logic             flush_inval,
   output logic             hit,
   output dcache_pkg::way_t hit_way,
   output dcache_pkg::way_t victim_way,
   output dcache_pkg::tag_t victim_tag,
   output logic             victim_dirty,
   output logic             flush_valid
);
   import dcache_pkg::*;

   tag_t                    tags  [`DCACHE_WAYS][`DCACHE_SETS];
   logic [`DCACHE_SETS-1:0] valid [`DCACHE_WAYS];
   logic [`DCACHE_SETS-1:0] dirty [`DCACHE_WAYS];
   logic [`DCACHE_SETS-1:0] lru;              // way to evict next, per set
   logic [`DCACHE_WAYS-1:0] match;
   idx_t                    vic_idx;

   // both ways compared in parallel, valid must be set
   always_comb begin
      hit_way = '0;
      for (int w = 0; w < `DCACHE_WAYS; w++) begin
         match[w] = valid[w][idx] && (tags[w][idx] == tag);
         if (match[w]) begin
            hit_way = way_t'(w);
         end
      end
   end

   assign hit = access && (|match); // only while a load or store is held

   // miss service picks the LRU way of the request set
   // during the sweep there is no access, so the port shows the swept block
   assign vic_idx      = access ? idx : flush_idx;
   assign victim_way   = access ? way_t'(lru[idx]) : flush_way;
   assign victim_tag   = tags[victim_way][vic_idx];
   assign victim_dirty = valid[victim_way][vic_idx] && dirty[victim_way][vic_idx];
   assign flush_valid  = valid[flush_way][flush_idx];

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         valid <= '{default: '0};
         dirty <= '{default: '0};
         lru   <= '0;                             // way 0 is the first victim
      end else begin
         if (hit) begin
            lru[idx] <= ~hit_way;                 // other way becomes LRU
         end
         if (store_hit) begin
            dirty[hit_way][idx] <= 1'b1;
         end
         if (fill_tag_we) begin                   // second fill word landed
            valid[victim_way][idx] <= 1'b1;
            dirty[victim_way][idx] <= 1'b0;
         end
         if (wb_clean) begin
            dirty[victim_way][idx] <= 1'b0;       // memory copy is current
         end
         if (flush_inval) begin
            valid[flush_way][flush_idx] <= 1'b0;
            dirty[flush_way][flush_idx] <= 1'b0;
         end
      end
   end

   // tag installed together with valid
   always_ff @(posedge CLK) begin
      if (fill_tag_we) begin
         tags[victim_way][idx] <= tag;
      end
   end

endmodule

`default_nettype wire

// File: flush_sweep_counter.sv
// position walks way first then set and sticks at the final one until reset
`timescale 1ns/1ps
`default_nettype none

module flush_sweep_counter (
   input  logic             CLK,
   input  logic             nRST,
   input  logic             step,
   output dcache_pkg::idx_t idx,
   output dcache_pkg::way_t way,
   output logic             last
);
   import dcache_pkg::*;

   localparam int POS_W = $clog2(FLUSH_STEPS);

   logic [POS_W-1:0] pos; // {set, way}

   // final block of the sweep
   assign last = (pos == POS_W'(FLUSH_STEPS - 1));

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         pos <= '0; // start at set 0 way 0
      end else if (step && !last) begin
         pos <= pos + 1'b1; // way is the low bit so it moves first
      end
   end

   // set above way, so both ways of a set are swept back to back
   assign {idx, way} = pos;

endmodule

`default_nettype wire

// File: tb_dcache.sv
// table rows run in order from the reset LRU state; memory model serves word accesses only
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
   import dcache_pkg::*;

   typedef enum {OP_RD, OP_WR, OP_HALT} op_t;

   typedef struct {
      op_t   op;
      addr_t addr;
      word_t wdata;
      logic  hit_now;   // rsp.hit expected in the first cycle
      addr_t wb_base;   // dirty victim block that goes out before the fill
   } row_t;

   typedef struct {
      logic  wen;
      addr_t addr;
      word_t data;
   } mem_op_t;

   localparam addr_t NO_WB = 32'hffff_ffff; // row causes no write-back

   logic        CLK;
   logic        nRST;
   cpu_req_t    req;
   cpu_rsp_t    rsp;
   mem_req_t    mem_req;
   logic        dwait;
   word_t       dload;

   word_t       mem_model [addr_t];  // written words only, the rest follow init_pattern
   word_t       shadow    [addr_t];  // what the processor expects to read
   mem_op_t     mem_log   [$];       // memory accesses completed during the current row
   row_t        table_q   [$];
   logic [31:0] lcg_state = 32'h907d;
   logic [31:0] rnd;
   logic        busy = 1'b0;         // memory access in progress
   int          wait_left = 0;
   int          cycles = 0;
   int          cycle_limit = 0;

   dcache dcache_i (.CLK, .nRST, .req, .rsp, .mem_req, .dwait, .dload);

   initial CLK = 1'b0;
   always #50 CLK = ~CLK;

   function automatic word_t init_pattern(input addr_t a);
      return a * 32'h9e37_79b9 + 32'h6b1f_c3a5; // odd multiplier, one value per address
   endfunction

   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic word_t mem_rd(input addr_t a);
      return mem_model.exists(a) ? mem_model[a] : init_pattern(a);
   endfunction

   function automatic word_t shadow_rd(input addr_t a);
      return shadow.exists(a) ? shadow[a] : init_pattern(a);
   endfunction

   task report_failure(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         report_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         report_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
      end
   endtask

   // memory side: a fresh access draws 0 to 3 wait cycles
   always @(negedge CLK) begin
      if (mem_req.ren || mem_req.wen) begin
         if (!busy) begin
            busy      = 1'b1;
            rnd       = lcg_next();
            wait_left = int'(rnd[17:16]);
         end
         dwait = (wait_left != 0);
         if (wait_left != 0) wait_left--;
         dload = mem_rd(mem_req.addr);  // sampled by the cache when dwait drops
      end else begin
         dwait = 1'b0;                  // idle bus never stalls
      end
   end

   // access completes at the edge that ends its dwait-low cycle
   always @(posedge CLK) begin
      if ((mem_req.ren || mem_req.wen) && !dwait) begin
         mem_log.push_back('{mem_req.wen, mem_req.addr, mem_req.wen ? mem_req.wdata : dload});
         if (mem_req.wen) mem_model[mem_req.addr] = mem_req.wdata;
         busy = 1'b0;
      end
   end

   always @(posedge CLK) begin
      cycles++;
      if (dcache_i.props_i.fail_count != 0) begin
         report_failure("a bound assertion on the cache handshake failed");
      end
      if (cycles > cycle_limit) begin
         report_failure($sformatf("timeout after %0d cycles, the cache stopped answering", cycles));
      end
   end

   task automatic add_row(input op_t op, input addr_t a, input word_t d, input logic h,
                          input addr_t wb);
      table_q.push_back('{op, a, d, h, wb});
   endtask

   // set = addr[5:3], word = addr[2], tag = addr[31:6]
   task automatic build_table();
      add_row(OP_RD,   32'h0000_0100, 32'h0,         1'b0, NO_WB);  // cold miss, set 0 way 0
      add_row(OP_RD,   32'h0000_0104, 32'h0,         1'b1, NO_WB);  // other word of the block
      add_row(OP_WR,   32'h0000_0108, 32'hdead_beef, 1'b0, NO_WB);  // store miss, set 1
      add_row(OP_RD,   32'h0000_0108, 32'h0,         1'b1, NO_WB);  // reads back the store
      add_row(OP_WR,   32'h0000_0100, 32'h1111_2222, 1'b1, NO_WB);  // set 0 way 0 now dirty
      add_row(OP_RD,   32'h0000_0200, 32'h0,         1'b0, NO_WB);  // fills way 1
      add_row(OP_RD,   32'h0000_0300, 32'h0,         1'b0, 32'h100); // third tag, dirty LRU out
      add_row(OP_RD,   32'h0000_0104, 32'h0,         1'b0, NO_WB);  // evicts clean tag 8
      add_row(OP_WR,   32'h0000_0304, 32'h3333_4444, 1'b1, NO_WB);
      add_row(OP_WR,   32'h0000_001c, 32'h5555_6666, 1'b0, NO_WB);  // set 3
      add_row(OP_RD,   32'h0000_003c, 32'h0,         1'b0, NO_WB);  // set 7
      add_row(OP_WR,   32'h0000_0208, 32'h7777_8888, 1'b0, NO_WB);  // set 1 way 1
      add_row(OP_RD,   32'h0000_0308, 32'h0,         1'b0, 32'h108); // set 1 dirty way 0 out
      add_row(OP_HALT, 32'h0000_0000, 32'h0,         1'b0, NO_WB);
   endtask

   // write-back words first, then the two fill reads of the requested block
   task automatic check_mem_log(input row_t row);
      mem_op_t exp_q [$];
      addr_t   blk;
      blk = {row.addr[31:3], 3'b000};
      if (!row.hit_now) begin
         if (row.wb_base != NO_WB) begin
            exp_q.push_back('{1'b1, row.wb_base, shadow_rd(row.wb_base)});
            exp_q.push_back('{1'b1, row.wb_base + 4, shadow_rd(row.wb_base + 4)});
         end
         exp_q.push_back('{1'b0, blk, shadow_rd(blk)});       // block not cached, memory current
         exp_q.push_back('{1'b0, blk + 4, shadow_rd(blk + 4)});
      end
      check_word("memory access count", word_t'(mem_log.size()), word_t'(exp_q.size()));
      foreach (exp_q[i]) begin
         check_flag("mem_req.wen", mem_log[i].wen, exp_q[i].wen);
         check_addr("mem_req.addr", mem_log[i].addr, exp_q[i].addr);
         check_word("memory data", mem_log[i].data, exp_q[i].data);
      end
   endtask

   task automatic run_row(input row_t row);
      @(negedge CLK);
      req       = '0;
      req.ren   = (row.op == OP_RD);
      req.wen   = (row.op == OP_WR);
      req.halt  = (row.op == OP_HALT);   // held to the end of the run
      req.addr  = row.addr;
      req.wdata = row.wdata;
      mem_log.delete();
      @(posedge CLK);
      if (row.op == OP_HALT) begin
         while (!rsp.flushed) @(posedge CLK);
      end else begin
         check_flag("rsp.flushed", rsp.flushed, 1'b0); // no sweep before halt
         check_flag("rsp.hit", rsp.hit, row.hit_now);
         if (row.hit_now) check_flag("mem_req.ren", mem_req.ren, 1'b0);
         while (!rsp.hit) @(posedge CLK);  // held until hit
         check_mem_log(row);
         if (row.op == OP_RD) begin
            check_word("rsp.rdata", rsp.rdata, shadow_rd(row.addr));
         end else begin
            shadow[row.addr] = row.wdata;   // store lands at this edge
         end
      end
   endtask

   task automatic compare_memory();
      foreach (mem_model[a]) begin
         check_word($sformatf("mem_model[%h]", a), mem_model[a], shadow_rd(a));
      end
      foreach (shadow[a]) begin
         check_word($sformatf("mem_model[%h]", a), mem_rd(a), shadow[a]);
      end
   endtask

   initial begin
      nRST  = 1'b0;
      req   = '0;
      dwait = 1'b0;
      dload = '0;
      build_table();
      // worst rows are dirty misses, flush steps wait at most 4 cycles
      cycle_limit = 5 + table_q.size() * 12 + 2 * FLUSH_STEPS * 5;
      repeat (5) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;
      foreach (table_q[r]) run_row(table_q[r]);
      compare_memory();  // after the flush every line is back in memory
      @(negedge CLK);    // assertions of the last edge have settled
      if (dcache_i.props_i.fail_count == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         report_failure("bound assertions on the memory handshake failed during the run");
      end
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
dcache_pkg.sv
flush_sweep_counter.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl_fsm.sv
dcache.sv
dcache_props.sv
tb_dcache.sv
